// ==== source/spi_bus_pkg.sv ====
////////////////////
// Wire-level facts shared by the SPI master and its testbench.
// Word length is fixed at 8 bits; DIO frames add one acknowledge bit.
// Mode bit 1 is CPOL and bit 0 is CPHA, as in the usual SPI numbering.
////////////////////
package spi_bus_pkg;

    localparam int word_len = 8;                  // Bits per SPI word.
    localparam int dio_len = word_len + 1;        // DIO adds the acknowledge slot.
    localparam int bit_count_w = $clog2(dio_len + 1); // Counter reaches dio_len.

    // Line levels while no frame is running.
    localparam logic ss_idle = 1'b1;              // Slave deselected.
    localparam logic mosi_idle = 1'b1;            // Released high, also the DIO stop level.

    // Bit shifted in behind the data. DIO needs a low ninth bit.
    localparam logic spi_fill = 1'b1;
    localparam logic dio_fill = 1'b0;

    typedef logic [word_len-1:0] spi_word_t;      // One data word.
    typedef logic [1:0] spi_mode_t;               // {CPOL, CPHA}.

    // Polarity set means sck idles high.
    function automatic logic mode_cpol(spi_mode_t m);
        return m[1];
    endfunction

    // Phase set means data is sampled on the second edge of each bit.
    function automatic logic mode_cpha(spi_mode_t m);
        return m[0];
    endfunction

endpackage

// ==== source/spi_host_pkg.sv ====
////////////////////
// Host-side facts: prescaler range and the transmit request layout.
// The prescaler is an exponent, 0 to 7; a half bit lasts 2**(p+1) clocks.
// The divider counter must hold 255 for the largest exponent.
////////////////////
package spi_host_pkg;

    import spi_bus_pkg::*;

    localparam int presc_w = 3;       // Prescaler exponent width.
    localparam int div_cnt_w = 8;     // Divider counter width, up to 255.

    // Everything the shift engine needs to run one frame.
    // The settings travel with the word so a queued word keeps its own framing.
    typedef struct packed {
        spi_word_t              data;       // Word to shift out.
        logic [presc_w-1:0]     prescaler;  // Clock divider exponent.
        spi_mode_t              mode;       // CPOL and CPHA.
        logic                   lsb_first;  // Bit order.
        logic                   dio;        // TM1637-style framing.
    } tx_request_t;

endpackage

// ==== source/spi_mailbox.sv ====
////////////////////
// One-word holding register with a full flag.
// A load while full is dropped and raises the sticky overrun flag.
// The stored word keeps its last value after take; only full tells it apart.
////////////////////
`timescale 1ns/1ps

module spi_mailbox #(
    parameter type payload_t = logic
) (
    input  logic     wr,
    input  logic     rst_n,
    input  logic     load,           // Write strobe from the producer.
    input  payload_t load_data,
    input  logic     take,           // Consumer has used the word.
    input  logic     overrun_clear,  // Clears the sticky overrun flag.
    output payload_t data,
    output logic     full,
    output logic     overrun
);

    logic accept;   // Load that finds the box empty.
    logic reject;   // Load that finds the box full.

    assign accept = load && !full;
    assign reject = load && full;

    ////////////////////
    // Payload register.
    ////////////////////
    always_ff @(posedge wr) begin
        if (accept) begin
            data <= load_data;  // Only an empty box takes a new word.
        end
    end

    ////////////////////
    // Flags.
    ////////////////////
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            // Take only happens while full, so it never meets an accept.
            if (accept) begin
                full <= 1'b1;
            end else if (take) begin
                full <= 1'b0;
            end

            // A lost word wins over a clear on the same edge, so no loss goes unseen.
            if (reject) begin
                overrun <= 1'b1;
            end else if (overrun_clear) begin
                overrun <= 1'b0;
            end
        end
    end

endmodule

// ==== source/spi_clock_divider.sv ====
////////////////////
// Half bit period timer.
// Emits half_tick on the last clock of every 2**(prescaler+1) clocks.
// Restarts from zero whenever run is low.
////////////////////
`timescale 1ns/1ps

module spi_clock_divider
    import spi_host_pkg::*;
(
    input  logic               wr,
    input  logic               rst_n,
    input  logic               run,        // High while a frame is in flight.
    input  logic [presc_w-1:0] prescaler,  // Exponent latched by the engine.
    output logic               half_tick   // End of one half bit period.
);

    localparam int span_w = div_cnt_w + 1;  // Room for 2**(7+1) = 256.

    logic [div_cnt_w-1:0] cnt;     // Clocks elapsed in this half period.
    logic [span_w-1:0]    span;    // Clocks per half period.
    logic [div_cnt_w-1:0] limit;   // Terminal count.

    assign span  = span_w'(2) << prescaler;       // Two to the power (p+1).
    assign limit = div_cnt_w'(span - span_w'(1)); // Last count before wrap.

    assign half_tick = run && (cnt == limit);

    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || half_tick) begin
            cnt <= '0;          // Idle, or wrap into the next half period.
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== source/spi_shift_engine.sv ====
////////////////////
// Frame controller for SPI and DIO transfers.
// Takes one request at a time and chains the next one without raising ss.
// sck, mosi and ss change only on clock edges of wr.
// In DIO mode the ninth bit is driven low and not stored in rx_word.
////////////////////
`timescale 1ns/1ps

module spi_shift_engine
    import spi_bus_pkg::*, spi_host_pkg::*;
(
    input  logic               wr,
    input  logic               rst_n,
    input  logic               tx_pending,  // Transmit mailbox holds a word.
    input  tx_request_t        request,     // Word and its framing.
    input  logic               half_tick,   // From the clock divider.
    input  logic               miso,
    output logic               take,        // Empties the transmit mailbox.
    output logic               run,         // Keeps the divider counting.
    output logic [presc_w-1:0] prescaler,   // Exponent for the running frame.
    output logic               rx_load,     // Received word is complete.
    output spi_word_t          rx_word,
    output logic               sck,
    output logic               mosi,
    output logic               ss
);

    logic                   busy;        // A frame is running.
    logic                   phase;       // Internal clock, 0 on the leading half.
    spi_mode_t              mode_q;      // Latched mode.
    logic                   lsb_q;       // Latched bit order.
    logic                   dio_q;       // Latched framing.
    logic [bit_count_w-1:0] bit_cnt;     // Bits completed in this frame.
    spi_word_t              tx_shift;    // Bits still to send, head first.
    spi_word_t              rx_shift;    // Bits gathered so far.
    spi_word_t              tx_next;
    spi_word_t              rx_next;
    logic                   mosi_q;      // Data line before the ss override.
    logic                   tx_head;     // Bit at the head of tx_shift.
    logic                   fill_bit;
    logic                   sample_now;  // This half_tick is the sampling edge.
    logic                   sample_en;   // Still inside the data bits.
    logic                   last_bit;
    logic                   frame_end;
    logic                   first_bit;   // First bit of the waiting request.
    logic                   start_mosi;  // Data line level when a frame starts.

    ////////////////////
    // Datapath helpers.
    ////////////////////
    assign fill_bit   = dio_q ? dio_fill : spi_fill;
    assign tx_head    = lsb_q ? tx_shift[0] : tx_shift[word_len-1];
    assign sample_now = (phase == mode_cpha(mode_q));  // Sample edge follows CPHA.
    assign sample_en  = (bit_cnt < bit_count_w'(word_len)); // Skip the DIO ack slot.
    assign last_bit   = dio_q ? (bit_cnt == bit_count_w'(dio_len - 1))
                              : (bit_cnt == bit_count_w'(word_len - 1));

    // Move the head bit out and let the fill bit trail behind the data.
    assign tx_next = lsb_q ? {fill_bit, tx_shift[word_len-1:1]}
                           : {tx_shift[word_len-2:0], fill_bit};
    // Received bits enter from the end opposite the transmit head.
    assign rx_next = lsb_q ? {miso, rx_shift[word_len-1:1]}
                           : {rx_shift[word_len-2:0], miso};

    // The frame ends on the trailing edge of its last bit.
    assign frame_end = busy && half_tick && phase && last_bit;
    assign take      = tx_pending && (!busy || frame_end); // Idle start or chain.
    assign rx_load   = frame_end;

    // With CPHA set the last sample lands on the closing edge, so pass it through.
    assign rx_word = (sample_now && sample_en) ? rx_next : rx_shift;

    always_comb begin
        first_bit = request.lsb_first ? request.data[0] : request.data[word_len-1];
        if (!mode_cpha(request.mode)) begin
            start_mosi = first_bit;      // Phase 0 needs data before the first edge.
        end else if (request.dio) begin
            start_mosi = 1'b0;           // DIO start condition.
        end else begin
            start_mosi = mosi_idle;
        end
    end

    ////////////////////
    // Frame FSM and shift registers.
    ////////////////////
    always_ff @(posedge wr or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            phase     <= 1'b0;
            mode_q    <= '0;          // Mode 0 gives a low idle sck.
            lsb_q     <= 1'b0;
            dio_q     <= 1'b0;
            prescaler <= '0;
            bit_cnt   <= '0;
            mosi_q    <= mosi_idle;
            ss        <= ss_idle;
        end else if (take) begin
            busy      <= 1'b1;        // Start, or carry straight on into the next word.
            phase     <= 1'b0;
            mode_q    <= request.mode;
            lsb_q     <= request.lsb_first;
            dio_q     <= request.dio;
            prescaler <= request.prescaler;
            bit_cnt   <= '0;
            mosi_q    <= start_mosi;
            ss        <= 1'b0;
        end else if (busy && half_tick) begin
            phase <= ~phase;          // Each half_tick is one sck edge.
            if (!sample_now) begin
                mosi_q <= tx_head;    // Launch edge.
            end
            if (phase) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (frame_end) begin
                busy <= 1'b0;         // Nothing queued behind this word.
                ss   <= ss_idle;
                if (dio_q) begin
                    mosi_q <= mosi_idle; // DIO stop: data rises while sck is high.
                end
            end
        end
    end

    // Shift registers carry payload only, so they have no reset.
    always_ff @(posedge wr) begin
        if (take) begin
            tx_shift <= request.data;
        end else if (busy && half_tick && sample_now) begin
            tx_shift <= tx_next;
            if (sample_en) begin
                rx_shift <= rx_next;
            end
        end
    end

    ////////////////////
    // Pins.
    ////////////////////
    assign run  = busy;
    assign sck  = phase ^ mode_cpol(mode_q);          // Inverted for idle-high modes.
    assign mosi = (ss && !dio_q) ? mosi_idle : mosi_q; // SPI parks mosi high when deselected.

endmodule

// ==== source/spi_master.sv ====
////////////////////
// SPI master top level with optional DIO framing.
// Host strobes are single-cycle and synchronous to wr.
// Words written while tx_empty is low are dropped and flagged.
// Frames that finish while rx_ready is high are dropped and flagged.
////////////////////
`timescale 1ns/1ps

module spi_master
    import spi_bus_pkg::*, spi_host_pkg::*;
(
    input  logic               wr,
    input  logic               rst_n,
    input  logic               tx_write,       // Strobe, carries the fields below.
    input  spi_word_t          tx_data,
    input  logic [presc_w-1:0] prescaler,
    input  spi_mode_t          mode,
    input  logic               lsb_first,
    input  logic               dio,
    input  logic               rx_read,        // Strobe, empties the receive box.
    input  logic               overrun_clear,  // Clears both overrun flags.
    input  logic               miso,
    output logic               tx_empty,
    output logic               tx_overrun,
    output spi_word_t          rx_data,        // Valid while rx_ready is high.
    output logic               rx_ready,
    output logic               rx_overrun,
    output logic               sck,
    output logic               mosi,
    output logic               ss
);

    tx_request_t        tx_req_in;   // Host fields bundled for the mailbox.
    tx_request_t        tx_req;      // Word waiting for the engine.
    logic               tx_pending;
    logic               take;
    logic               run;
    logic               half_tick;
    logic [presc_w-1:0] eng_prescaler;
    logic               rx_load;
    spi_word_t          rx_word;

    assign tx_req_in = '{data: tx_data, prescaler: prescaler, mode: mode,
                         lsb_first: lsb_first, dio: dio};
    assign tx_empty  = ~tx_pending;

    spi_mailbox #(.payload_t(tx_request_t)) tx_box (
        .wr(wr), .rst_n(rst_n),
        .load(tx_write), .load_data(tx_req_in), .take(take),
        .overrun_clear(overrun_clear),
        .data(tx_req), .full(tx_pending), .overrun(tx_overrun)
    );

    spi_mailbox #(.payload_t(spi_word_t)) rx_box (
        .wr(wr), .rst_n(rst_n),
        .load(rx_load), .load_data(rx_word), .take(rx_read),
        .overrun_clear(overrun_clear),
        .data(rx_data), .full(rx_ready), .overrun(rx_overrun)
    );

    spi_clock_divider u_divider (
        .wr(wr), .rst_n(rst_n),
        .run(run), .prescaler(eng_prescaler), .half_tick(half_tick)
    );

    spi_shift_engine u_engine (
        .wr(wr), .rst_n(rst_n),
        .tx_pending(tx_pending), .request(tx_req), .half_tick(half_tick), .miso(miso),
        .take(take), .run(run), .prescaler(eng_prescaler),
        .rx_load(rx_load), .rx_word(rx_word),
        .sck(sck), .mosi(mosi), .ss(ss)
    );

endmodule

// ==== testbench/spi_master_properties.sv ====
////////////////////
// Protocol checks bound into the SPI master top level.
// Reaches into the shift engine for the latched mode and framing.
////////////////////
`timescale 1ns/1ps

module spi_master_properties
    import spi_bus_pkg::*;
(
    input logic      wr,
    input logic      rst_n,
    input logic      ss,
    input logic      sck,
    input logic      mosi,
    input logic      tx_empty,
    input logic      take,
    input logic      rx_load,
    input logic      rx_ready,
    input logic      rx_overrun,
    input spi_mode_t mode_q,      // Mode of the last frame.
    input logic      dio_q        // Framing of the last frame.
);

    // Between frames sck rests at the polarity level.
    idle_sck: assert property (@(posedge wr) disable iff (!rst_n)
        (ss && !dio_q) |-> (sck == mode_q[1]))
        else $error("sck moved away from its idle level while ss is high");

    // SPI parks mosi high and DIO releases it high at the stop, so it is high in both.
    idle_mosi: assert property (@(posedge wr) disable iff (!rst_n)
        ss |-> mosi)
        else $error("mosi is low while ss is high");

    // A word the engine takes leaves the transmit mailbox empty on the next edge.
    tx_take: assert property (@(posedge wr) disable iff (!rst_n)
        take |=> tx_empty)
        else $error("tx_empty stayed low after the engine took the word");

    // A receive overrun needs a finished frame meeting a full mailbox.
    rx_overrun_cause: assert property (@(posedge wr) disable iff (!rst_n)
        $rose(rx_overrun) |-> $past(rx_load && rx_ready))
        else $error("rx_overrun rose without a frame landing on a full mailbox");

endmodule

bind spi_master spi_master_properties props (
    .wr(wr), .rst_n(rst_n), .ss(ss), .sck(sck), .mosi(mosi),
    .tx_empty(tx_empty), .take(take),
    .rx_load(rx_load), .rx_ready(rx_ready), .rx_overrun(rx_overrun),
    .mode_q(u_engine.mode_q), .dio_q(u_engine.dio_q)
);

// ==== testbench/spi_master_tb.sv ====
////////////////////
// Testbench for the SPI master with a behavioral slave on the pins.
// Frames come from testbench/spi_master_vectors.txt, one per line.
// Back-to-back words must share clock polarity.
// The slave counts an sck edge only if ss was low before it.
////////////////////
`timescale 1ns/1ps

module spi_master_tb
    import spi_bus_pkg::*, spi_host_pkg::*;
();

    localparam realtime clk_period = 40.0;  // ns.

    typedef struct packed {
        spi_mode_t          mode;
        logic               lsb;
        logic               dio;
        logic [presc_w-1:0] presc;
        spi_word_t          tx;     // Word the master sends.
        spi_word_t          reply;  // Word the slave answers with.
    } frame_t;

    logic wr, rst_n, tx_write, lsb_first, dio, rx_read, overrun_clear, miso;
    logic tx_empty, tx_overrun, rx_ready, rx_overrun, sck, mosi, ss;
    logic [presc_w-1:0] prescaler;
    spi_mode_t mode;
    spi_word_t tx_data, rx_data;

    frame_t  vec [0:31];
    frame_t  pending [$];     // Accepted words not yet seen on the wire.
    frame_t  cur;
    int      n_vec, errors, frames_done, ss_rises, edges, gap, idx, i, fd, code, target;
    int      m, l, d, p, t, r;
    string   line;
    spi_word_t cap;           // Word rebuilt from mosi.
    logic    prev_ss, prev_sck, prev_mosi;
    realtime watchdog_limit = 0;

    spi_master dut (.*);

    initial begin
        wr = 1'b0;
        forever #(clk_period / 2) wr = ~wr;
    end

    task automatic check_value(string name, int exp, int got);
        assert (exp == got) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    // Reply bit on the line after n sck edges of the frame.
    function automatic logic reply_bit(frame_t f, int n);
        int k;
        k = f.mode[0] ? ((n == 0) ? 0 : (n - 1) / 2) : n / 2;
        if (k >= word_len) return 1'b0;   // DIO acknowledge slot.
        return f.lsb ? f.reply[k] : f.reply[word_len - 1 - k];
    endfunction

    ////////////////////
    // Slave model, sampled between wr edges where the pins are stable.
    ////////////////////
    always @(negedge wr) begin
        if (!rst_n) begin
            prev_ss = ss;
            prev_sck = sck;
            prev_mosi = mosi;
        end else begin
            gap++;                                  // wr cycles since the last event.
            if (prev_ss && !ss) begin
                assert (pending.size() > 0) else begin
                    errors++;
                    $display("ss fell at %0t with no word queued", $time);
                end
                edges = 0;
                gap = 0;
                cap = '0;
                if (pending.size() > 0 && pending[0].dio) begin
                    check_value("mosi at DIO start", 0, mosi);  // Start condition.
                end
            end else if (!prev_ss && sck != prev_sck && pending.size() > 0) begin
                // The closing edge of a frame comes together with ss rising.
                cur = pending[0];
                check_value("sck half period", 1 << (cur.presc + 1), gap);
                gap = 0;
                if (edges[0] == cur.mode[0]) begin   // Sampling edge of this mode.
                    idx = edges / 2;
                    if (idx < word_len) begin
                        cap[cur.lsb ? idx : word_len - 1 - idx] = prev_mosi;
                    end else begin
                        check_value("DIO ninth mosi bit", 0, prev_mosi);
                    end
                end
                edges++;
                if (edges == 2 * (cur.dio ? dio_len : word_len)) begin
                    check_value("mosi word", cur.tx, cap);
                    void'(pending.pop_front());
                    edges = 0;
                    cap = '0;
                    frames_done++;
                end
            end
            if (!prev_ss && ss) begin
                ss_rises++;
                check_value("sck edges left at ss rise", 0, edges);
                check_value("mosi after frame", 1, mosi);
            end
            prev_ss = ss;
            prev_sck = sck;
            prev_mosi = mosi;
            miso = (pending.size() > 0) ? reply_bit(pending[0], edges) : 1'b1;
        end
    end

    ////////////////////
    // Host side tasks, entered on a falling edge.
    ////////////////////
    task automatic write_frame(frame_t f);
        if (tx_empty) pending.push_back(f);       // Only an empty mailbox accepts.
        {mode, lsb_first, dio, prescaler, tx_data} = {f.mode, f.lsb, f.dio, f.presc, f.tx};
        tx_write = 1'b1;
        @(negedge wr);
        tx_write = 1'b0;
    endtask

    task automatic pulse_read();
        rx_read = 1'b1;
        @(negedge wr);
        rx_read = 1'b0;
    endtask

    task automatic run_frame(frame_t f);
        write_frame(f);
        while (!rx_ready) @(negedge wr);
        check_value("rx_data", f.reply, rx_data);
        pulse_read();
        repeat ($urandom_range(1, 6)) @(negedge wr);   // Idle gap.
    endtask

    initial begin
        wait (watchdog_limit > 0);
        #(watchdog_limit);
        $display("Timeout: the run did not finish within %0t", $time);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(45));
        {rst_n, tx_write, rx_read, overrun_clear, lsb_first, dio} = '0;
        {mode, prescaler, tx_data} = '0;
        miso = 1'b1;
        fd = $fopen("testbench/spi_master_vectors.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("The vector file could not be opened");
        end
        while (fd != 0 && !$feof(fd) && n_vec < 32) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 2 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d %d %h %h", m, l, d, p, t, r) == 6) begin
                    vec[n_vec] = '{m, l, d, p, t, r};
                    n_vec++;
                end
            end
        end
        // Every frame at the slowest prescaler, twice over.
        watchdog_limit = 2.0 * (n_vec + 6) * (2 * dio_len) * 256 * clk_period;
        repeat (4) @(negedge wr);
        rst_n = 1'b1;
        @(negedge wr);
        check_value("ss after reset", 1, ss);
        check_value("sck after reset", 0, sck);
        check_value("mosi after reset", 1, mosi);
        check_value("tx_empty after reset", 1, tx_empty);
        check_value("rx_ready after reset", 0, rx_ready);
        check_value("tx_overrun after reset", 0, tx_overrun);
        check_value("rx_overrun after reset", 0, rx_overrun);
        if (n_vec >= 4) begin
            for (i = 0; i < n_vec; i++) run_frame(vec[i]);
            write_frame(vec[0]);                       // Second write hits a full mailbox.
            write_frame(vec[1]);
            check_value("tx_overrun", 1, tx_overrun);
            while (!rx_ready) @(negedge wr);
            check_value("rx_data after tx overrun", vec[0].reply, rx_data);
            pulse_read();
            overrun_clear = 1'b1;
            @(negedge wr);
            overrun_clear = 1'b0;
            check_value("tx_overrun after clear", 0, tx_overrun);
            target = frames_done + 2;                  // The unread frame and the dropped one.
            write_frame(vec[2]);                       // Left unread on purpose.
            while (!rx_ready) @(negedge wr);
            write_frame(vec[3]);
            while (frames_done < target) @(negedge wr);
            check_value("rx_overrun", 1, rx_overrun);
            check_value("rx_data kept", vec[2].reply, rx_data);
            pulse_read();
            overrun_clear = 1'b1;
            @(negedge wr);
            overrun_clear = 1'b0;
            check_value("rx_overrun after clear", 0, rx_overrun);
            target = ss_rises + 1;                     // Two words, one deselect.
            write_frame(vec[n_vec - 2]);
            while (!tx_empty) @(negedge wr);
            write_frame(vec[n_vec - 1]);
            while (!rx_ready) @(negedge wr);
            check_value("rx_data first chained", vec[n_vec - 2].reply, rx_data);
            pulse_read();
            while (!rx_ready) @(negedge wr);
            check_value("rx_data second chained", vec[n_vec - 1].reply, rx_data);
            pulse_read();
            check_value("ss rises over chained words", target, ss_rises);
            check_value("ss after last word", 1, ss);
        end else begin
            errors++;
            $display("Only %0d vectors were read, at least 4 are needed", n_vec);
        end
        $display("Errors: %0d, frames seen on the wire: %0d", errors, frames_done);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/spi_bus_pkg.sv
source/spi_host_pkg.sv
source/spi_mailbox.sv
source/spi_clock_divider.sv
source/spi_shift_engine.sv
source/spi_master.sv
testbench/spi_master_properties.sv
testbench/spi_master_tb.sv

// ==== testbench/spi_master_vectors.txt ====
# mode lsb_first dio prescaler tx_word(hex) reply_word(hex)
# One frame per line. DIO frames use a phase-1 mode; the last two lines share polarity.
0 0 0 0 a5 3c
1 0 0 1 5a c3
2 0 0 2 81 7e
3 0 0 0 f0 0f
0 1 0 1 01 80
1 1 0 0 c6 39
2 1 0 3 7f fe
3 1 0 2 12 48
3 1 1 0 44 d2
3 1 1 1 ff 00
1 0 1 2 0e 71
0 0 0 7 96 69
2 0 0 0 33 cc
2 0 0 1 b4 2d
